/* hdl/bus_pkg.sv */
////////////////////
// Host bus definitions
// Address, data, strobe and burst length widths of the host side
// and the address map of the attached memory chips
////////////////////

package bus_pkg;

    // Host byte address width
    localparam int unsigned ADDR_W = 32;

    // Host data beat width
    localparam int unsigned DATA_W = 32;

    // Byte strobes per beat
    localparam int unsigned STRB_W = DATA_W / 8;

    // Burst length field holds beats minus one
    localparam int unsigned LEN_W = 8;

    // Two chips of 8 MiB each
    localparam int unsigned NUM_CHIPS = 2;

    // Address bit that picks the chip
    localparam int unsigned CHIP_SEL_BIT = 23;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [DATA_W-1:0] data_t;

    typedef logic [STRB_W-1:0] strb_t;

    typedef logic [LEN_W-1:0] len_t;

endpackage

/* hdl/hyper_ax_arbiter.sv */
////////////////////
// Read/write request arbiter
// Round-robin between the read and write request channels
// with lock-in, since HyperBus carries one transaction at a time
////////////////////

`timescale 1ns/1ns

module hyper_ax_arbiter (
    input  logic           clk_i,
    input  logic           rst_ni,
    // Read request
    input  logic           ar_valid_i,
    input  bus_pkg::addr_t ar_addr_i,
    input  bus_pkg::len_t  ar_len_i,
    output logic           ar_ready_o,
    // Write request
    input  logic           aw_valid_i,
    input  bus_pkg::addr_t aw_addr_i,
    input  bus_pkg::len_t  aw_len_i,
    output logic           aw_ready_o,
    // Granted request
    output logic           req_valid_o,
    output bus_pkg::addr_t req_addr_o,
    output bus_pkg::len_t  req_len_o,
    output logic           req_write_o,
    input  logic           req_ready_i
);

    // High gives the write channel priority on a tie
    logic prio_q;
    logic lock_q;
    logic sel_q;
    // High selects the write request
    logic sel;
    logic grant;

    always_comb begin
        if (lock_q) begin
            sel = sel_q;
        end else if (ar_valid_i && aw_valid_i) begin
            sel = prio_q;
        end else begin
            sel = aw_valid_i;
        end
    end

    assign req_valid_o = sel ? aw_valid_i : ar_valid_i;
    assign req_addr_o  = sel ? aw_addr_i : ar_addr_i;
    assign req_len_o   = sel ? aw_len_i : ar_len_i;
    assign req_write_o = sel;

    assign ar_ready_o = req_ready_i & ~sel;
    assign aw_ready_o = req_ready_i & sel;

    assign grant = req_valid_o & req_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q <= 1'b0;
            lock_q <= 1'b0;
            sel_q  <= 1'b0;
        end else if (grant) begin
            // Loser of this round wins the next tie
            prio_q <= ~sel;
            lock_q <= 1'b0;
        end else if (req_valid_o) begin
            // Offered but not taken, hold the choice
            lock_q <= 1'b1;
            sel_q  <= sel;
        end
    end

endmodule

/* hdl/hyper_cmd_builder.sv */
////////////////////
// Command builder
// One-entry register stage that turns a granted request into
// a command-address word, a chip select and a word burst length
////////////////////

`timescale 1ns/1ns

module hyper_cmd_builder (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // Granted request
    input  logic                    req_valid_i,
    input  bus_pkg::addr_t          req_addr_i,
    input  bus_pkg::len_t           req_len_i,
    input  logic                    req_write_i,
    output logic                    req_ready_o,
    // Transaction to the PHY
    output logic                    trans_valid_o,
    output hyper_pkg::hyper_ca_t    trans_ca_o,
    output hyper_pkg::cs_t          trans_cs_o,
    output hyper_pkg::hyper_burst_t trans_burst_o,
    input  logic                    trans_ready_i
);

    import bus_pkg::*;
    import hyper_pkg::*;

    logic         valid_q;
    hyper_ca_t    ca_d, ca_q;
    cs_t          cs_d, cs_q;
    hyper_burst_t burst_d, burst_q;
    addr_t        word_addr;
    logic         load;

    // Register free or emptying this cycle
    assign req_ready_o = ~valid_q | trans_ready_i;
    assign load        = req_valid_i & req_ready_o;

    assign word_addr = req_addr_i >> 1;

    always_comb begin
        ca_d.fields.read       = ~req_write_i;
        // Memory space, linear burst
        ca_d.fields.addr_space = 1'b0;
        ca_d.fields.linear     = 1'b1;
        ca_d.fields.addr_upper = word_addr[ADDR_W-1:CA_LOWER_W];
        ca_d.fields.reserved   = '0;
        ca_d.fields.addr_lower = word_addr[CA_LOWER_W-1:0];
    end

    always_comb begin
        cs_d                           = '0;
        cs_d[req_addr_i[CHIP_SEL_BIT]] = 1'b1;
    end

    // Two HyperBus words per host beat
    assign burst_d = (hyper_burst_t'(req_len_i) + hyper_burst_t'(1)) << 1;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (req_ready_o) begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            ca_q    <= ca_d;
            cs_q    <= cs_d;
            burst_q <= burst_d;
        end
    end

    assign trans_valid_o = valid_q;
    assign trans_ca_o    = ca_q;
    assign trans_cs_o    = cs_q;
    assign trans_burst_o = burst_q;

endmodule

/* hdl/hyper_frontend.sv */
////////////////////
// HyperBus controller front end
// Arbitrates host requests into PHY transactions and converts
// the data paths between 32-bit beats and 16-bit words
////////////////////

`timescale 1ns/1ns

module hyper_frontend (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // Host read request
    input  logic                    ar_valid_i,
    input  bus_pkg::addr_t          ar_addr_i,
    input  bus_pkg::len_t           ar_len_i,
    output logic                    ar_ready_o,
    // Host write request
    input  logic                    aw_valid_i,
    input  bus_pkg::addr_t          aw_addr_i,
    input  bus_pkg::len_t           aw_len_i,
    output logic                    aw_ready_o,
    // Host write data
    input  logic                    w_valid_i,
    input  bus_pkg::data_t          w_data_i,
    input  bus_pkg::strb_t          w_strb_i,
    input  logic                    w_last_i,
    output logic                    w_ready_o,
    // Host read data
    output logic                    r_valid_o,
    output bus_pkg::data_t          r_data_o,
    output logic                    r_error_o,
    output logic                    r_last_o,
    input  logic                    r_ready_i,
    // Host write response
    output logic                    b_valid_o,
    output logic                    b_error_o,
    input  logic                    b_ready_i,
    // PHY transaction
    output logic                    trans_valid_o,
    output hyper_pkg::hyper_ca_t    trans_ca_o,
    output hyper_pkg::cs_t          trans_cs_o,
    output hyper_pkg::hyper_burst_t trans_burst_o,
    input  logic                    trans_ready_i,
    // PHY write words
    output logic                    tx_valid_o,
    output hyper_pkg::hyper_word_t  tx_data_o,
    output hyper_pkg::hyper_strb_t  tx_strb_o,
    output logic                    tx_last_o,
    input  logic                    tx_ready_i,
    // PHY read words
    input  logic                    rx_valid_i,
    input  hyper_pkg::hyper_word_t  rx_data_i,
    input  logic                    rx_error_i,
    input  logic                    rx_last_i,
    output logic                    rx_ready_o,
    // PHY write response
    input  logic                    b_valid_i,
    input  logic                    b_error_i,
    output logic                    b_ready_o
);

    import bus_pkg::*;

    logic  req_valid;
    addr_t req_addr;
    len_t  req_len;
    logic  req_write;
    logic  req_ready;

    hyper_ax_arbiter i_ax_arbiter (
        .clk_i       ( clk_i      ),
        .rst_ni      ( rst_ni     ),
        .ar_valid_i  ( ar_valid_i ),
        .ar_addr_i   ( ar_addr_i  ),
        .ar_len_i    ( ar_len_i   ),
        .ar_ready_o  ( ar_ready_o ),
        .aw_valid_i  ( aw_valid_i ),
        .aw_addr_i   ( aw_addr_i  ),
        .aw_len_i    ( aw_len_i   ),
        .aw_ready_o  ( aw_ready_o ),
        .req_valid_o ( req_valid  ),
        .req_addr_o  ( req_addr   ),
        .req_len_o   ( req_len    ),
        .req_write_o ( req_write  ),
        .req_ready_i ( req_ready  )
    );

    hyper_cmd_builder i_cmd_builder (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .req_valid_i   ( req_valid     ),
        .req_addr_i    ( req_addr      ),
        .req_len_i     ( req_len       ),
        .req_write_i   ( req_write     ),
        .req_ready_o   ( req_ready     ),
        .trans_valid_o ( trans_valid_o ),
        .trans_ca_o    ( trans_ca_o    ),
        .trans_cs_o    ( trans_cs_o    ),
        .trans_burst_o ( trans_burst_o ),
        .trans_ready_i ( trans_ready_i )
    );

    hyper_w_split i_w_split (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .w_valid_i  ( w_valid_i  ),
        .w_data_i   ( w_data_i   ),
        .w_strb_i   ( w_strb_i   ),
        .w_last_i   ( w_last_i   ),
        .w_ready_o  ( w_ready_o  ),
        .tx_valid_o ( tx_valid_o ),
        .tx_data_o  ( tx_data_o  ),
        .tx_strb_o  ( tx_strb_o  ),
        .tx_last_o  ( tx_last_o  ),
        .tx_ready_i ( tx_ready_i )
    );

    hyper_r_merge i_r_merge (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .rx_valid_i ( rx_valid_i ),
        .rx_data_i  ( rx_data_i  ),
        .rx_error_i ( rx_error_i ),
        .rx_last_i  ( rx_last_i  ),
        .rx_ready_o ( rx_ready_o ),
        .r_valid_o  ( r_valid_o  ),
        .r_data_o   ( r_data_o   ),
        .r_error_o  ( r_error_o  ),
        .r_last_o   ( r_last_o   ),
        .r_ready_i  ( r_ready_i  )
    );

    // Write response passes through unchanged
    assign b_valid_o = b_valid_i;
    assign b_error_o = b_error_i;
    assign b_ready_o = b_ready_i;

endmodule

/* hdl/hyper_pkg.sv */
////////////////////
// HyperBus definitions
// Word widths on the PHY side and the command-address word
// with its raw and field views
////////////////////

package hyper_pkg;

    // One HyperBus data word
    localparam int unsigned WORD_W = 16;

    // Burst length counted in 16-bit words
    localparam int unsigned BURST_W = 10;

    // Command-address word
    localparam int unsigned CA_W = 48;

    // Address field widths inside the command-address word
    localparam int unsigned CA_UPPER_W = 29;
    localparam int unsigned CA_RSVD_W  = 13;
    localparam int unsigned CA_LOWER_W = 3;

    typedef logic [WORD_W-1:0] hyper_word_t;

    typedef logic [WORD_W/8-1:0] hyper_strb_t;

    typedef logic [BURST_W-1:0] hyper_burst_t;

    // One-hot chip select
    typedef logic [bus_pkg::NUM_CHIPS-1:0] cs_t;

    // Field layout, most significant bit first as shifted out
    typedef struct packed {
        logic                  read;
        logic                  addr_space;
        logic                  linear;
        logic [CA_UPPER_W-1:0] addr_upper;
        logic [CA_RSVD_W-1:0]  reserved;
        logic [CA_LOWER_W-1:0] addr_lower;
    } hyper_ca_fields_t;

    typedef union packed {
        logic [CA_W-1:0]  raw;
        hyper_ca_fields_t fields;
    } hyper_ca_t;

endpackage

/* hdl/hyper_r_merge.sv */
////////////////////
// Read data merger
// Joins pairs of 16-bit PHY read words into 32-bit host beats
// and ORs the error flags of both words
////////////////////

`timescale 1ns/1ns

module hyper_r_merge (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // PHY read words
    input  logic                   rx_valid_i,
    input  hyper_pkg::hyper_word_t rx_data_i,
    input  logic                   rx_error_i,
    input  logic                   rx_last_i,
    output logic                   rx_ready_o,
    // Host read data
    output logic                   r_valid_o,
    output bus_pkg::data_t         r_data_o,
    output logic                   r_error_o,
    output logic                   r_last_o,
    input  logic                   r_ready_i
);

    import hyper_pkg::*;

    logic        lane_q;
    hyper_word_t buf_q;
    logic        err_q;
    logic        rx_fire;
    logic        r_fire;

    // First word always fits in the buffer
    assign rx_ready_o = ~lane_q | r_ready_i;
    assign rx_fire    = rx_valid_i & rx_ready_o;

    // Second word goes straight out with the buffered one
    assign r_valid_o = lane_q & rx_valid_i;
    assign r_data_o  = {rx_data_i, buf_q};
    assign r_error_o = err_q | rx_error_i;
    assign r_last_o  = rx_last_i;
    assign r_fire    = r_valid_o & r_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lane_q <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            if (rx_fire) begin
                lane_q <= ~lane_q;
            end
            if (rx_fire && !lane_q) begin
                err_q <= rx_error_i;
            end else if (r_fire) begin
                err_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_fire && !lane_q) begin
            buf_q <= rx_data_i;
        end
    end

endmodule

/* hdl/hyper_w_split.sv */
////////////////////
// Write data splitter
// Sends each 32-bit host beat as two 16-bit PHY words,
// lower half first
////////////////////

`timescale 1ns/1ns

module hyper_w_split (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Host write data
    input  logic                   w_valid_i,
    input  bus_pkg::data_t         w_data_i,
    input  bus_pkg::strb_t         w_strb_i,
    input  logic                   w_last_i,
    output logic                   w_ready_o,
    // PHY write words
    output logic                   tx_valid_o,
    output hyper_pkg::hyper_word_t tx_data_o,
    output hyper_pkg::hyper_strb_t tx_strb_o,
    output logic                   tx_last_o,
    input  logic                   tx_ready_i
);

    import hyper_pkg::*;

    // Low presents the lower half of the beat
    logic lane_q;
    logic tx_fire;

    assign tx_valid_o = w_valid_i;
    assign tx_fire    = tx_valid_o & tx_ready_i;

    assign tx_data_o = w_data_i[WORD_W*lane_q +: WORD_W];
    assign tx_strb_o = w_strb_i[$bits(hyper_strb_t)*lane_q +: $bits(hyper_strb_t)];

    // Burst ends on the upper word of the last beat
    assign tx_last_o = w_last_i & lane_q;

    // Beat leaves only with its upper half
    assign w_ready_o = lane_q & tx_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lane_q <= 1'b0;
        end else if (tx_fire) begin
            lane_q <= ~lane_q;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build the front end testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_hyper_frontend -f verilog.f \
    || { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/Vtb_hyper_frontend)"
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && exit 0 || exit 1

/* tests/hyper_frontend_assert.sv */
////////////////////
// Front end protocol checks
// PHY command stability, one-hot chip select and read beat
// validity, bound onto the front end top level
////////////////////

`timescale 1ns/1ns

module hyper_frontend_assert (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        trans_valid_i,
    input  logic [hyper_pkg::CA_W-1:0]  trans_ca_i,
    input  hyper_pkg::cs_t              trans_cs_i,
    input  hyper_pkg::hyper_burst_t     trans_burst_i,
    input  logic                        trans_ready_i,
    input  logic                        r_valid_i,
    input  logic                        rx_valid_i
);

    // Offered command holds until the PHY takes it
    trans_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        trans_valid_i && !trans_ready_i |=> trans_valid_i && $stable(trans_ca_i)
            && $stable(trans_cs_i) && $stable(trans_burst_i))
        else $error("PHY command changed before it was accepted");

    cs_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        trans_valid_i |-> $onehot(trans_cs_i))
        else $error("Chip select is not one-hot on a valid command");

    // Read beats only leave together with their second word
    r_needs_rx: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_i |-> rx_valid_i)
        else $error("Read beat valid without a PHY read word");

endmodule

bind hyper_frontend hyper_frontend_assert i_frontend_assert (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .trans_valid_i ( trans_valid_o ),
    .trans_ca_i    ( trans_ca_o    ),
    .trans_cs_i    ( trans_cs_o    ),
    .trans_burst_i ( trans_burst_o ),
    .trans_ready_i ( trans_ready_i ),
    .r_valid_i     ( r_valid_o     ),
    .rx_valid_i    ( rx_valid_i    )
);

/* tests/tb_hyper_frontend.sv */
////////////////////
// HyperBus front end testbench
// Plays the host and the PHY around the front end and checks
// commands, split write words, merged read beats and responses
////////////////////

`timescale 1ns/1ns

module tb_hyper_frontend;

    import bus_pkg::*;
    import hyper_pkg::*;

    localparam int TIMEOUT      = 200;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_CMDS     = 6;

    logic         clk_i;
    logic         rst_ni;
    logic         ar_valid_i, aw_valid_i, w_valid_i, w_last_i;
    addr_t        ar_addr_i, aw_addr_i;
    len_t         ar_len_i, aw_len_i;
    data_t        w_data_i;
    strb_t        w_strb_i;
    logic         ar_ready_o, aw_ready_o, w_ready_o;
    logic         r_valid_o, r_error_o, r_last_o, r_ready_i;
    data_t        r_data_o;
    logic         b_valid_o, b_error_o, b_ready_i;
    logic         trans_valid_o, trans_ready_i;
    hyper_ca_t    trans_ca_o;
    cs_t          trans_cs_o;
    hyper_burst_t trans_burst_o;
    logic         tx_valid_o, tx_last_o, tx_ready_i;
    hyper_word_t  tx_data_o, rx_data_i;
    hyper_strb_t  tx_strb_o;
    logic         rx_valid_i, rx_error_i, rx_last_i, rx_ready_o;
    logic         b_valid_i, b_error_i, b_ready_o;

    int errors;
    int checks;
    int tests;
    int mark;
    bit hung;

    hyper_frontend dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Expected PHY command outputs for a host request
    function automatic logic [CA_W-1:0] expected_ca(input addr_t addr, input logic is_read);
        addr_t wa;
        wa = addr >> 1;
        return {is_read, 1'b0, 1'b1, wa[31:3], 13'd0, wa[2:0]};
    endfunction

    function automatic cs_t expected_cs(input addr_t addr);
        return cs_t'(1 << addr[CHIP_SEL_BIT]);
    endfunction

    function automatic hyper_burst_t expected_burst(input len_t len);
        return hyper_burst_t'(2 * (int'(len) + 1));
    endfunction

    task automatic report_mismatch(input string what, input string want_s, input string got_s);
        errors++;
        $display("[ERROR] %0t ns %s: expected %s, got %s", $time, what, want_s, got_s);
    endtask

    task automatic compare_ca(input hyper_ca_t got, input logic [CA_W-1:0] want,
                              input string what);
        checks++;
        if (got.raw !== want) begin
            report_mismatch(what, $sformatf("%h", want), $sformatf("%h", got.raw));
        end
    endtask

    task automatic compare_cs(input cs_t got, input cs_t want, input string what);
        checks++;
        if (got !== want) report_mismatch(what, $sformatf("%b", want), $sformatf("%b", got));
    endtask

    task automatic compare_burst(input hyper_burst_t got, input hyper_burst_t want,
                                 input string what);
        checks++;
        if (got !== want) report_mismatch(what, $sformatf("%0d", want), $sformatf("%0d", got));
    endtask

    task automatic compare_word(input hyper_word_t got, input hyper_word_t want,
                                input string what);
        checks++;
        if (got !== want) report_mismatch(what, $sformatf("%h", want), $sformatf("%h", got));
    endtask

    task automatic compare_strb(input hyper_strb_t got, input hyper_strb_t want,
                                input string what);
        checks++;
        if (got !== want) report_mismatch(what, $sformatf("%b", want), $sformatf("%b", got));
    endtask

    task automatic compare_beat(input data_t got, input data_t want, input string what);
        checks++;
        if (got !== want) report_mismatch(what, $sformatf("%h", want), $sformatf("%h", got));
    endtask

    task automatic compare_bit(input logic got, input logic want, input string what);
        checks++;
        if (got !== want) report_mismatch(what, $sformatf("%b", want), $sformatf("%b", got));
    endtask

    task automatic timeout_hit(input string what);
        hung = 1'b1;
        $display("Timeout: no progress while waiting for %s", what);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (hung) begin
            $display("%s: stopped by a timeout", name);
        end else if (errors == mark) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, errors - mark);
        end
        mark = errors;
    endtask

    task automatic reset_dut();
        @(negedge clk_i);
        rst_ni = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
    endtask

    task automatic random_request(output logic is_read, output addr_t addr, output len_t len);
        is_read = 1'($urandom % 2);
        addr    = $urandom & 32'h00FF_FFFC;
        len     = len_t'($urandom % 16);
    endtask

    // Command register must fill exactly one cycle after the ar handshake
    task automatic test_single_read(input logic chip);
        logic  is_read;
        addr_t addr;
        len_t  len;
        int    steps;
        random_request(is_read, addr, len);
        addr[CHIP_SEL_BIT] = chip;
        steps = 0;
        @(negedge clk_i);
        trans_ready_i = 1'b0;
        ar_valid_i    = 1'b1;
        ar_addr_i     = addr;
        ar_len_i      = len;
        #1;
        while (!ar_ready_o) begin
            steps++;
            if (steps > TIMEOUT) begin
                timeout_hit("the read request handshake");
                return;
            end
            @(negedge clk_i);
            #1;
        end
        compare_bit(trans_valid_o, 1'b0, "command valid in handshake cycle");
        @(negedge clk_i);
        ar_valid_i = 1'b0;
        #1;
        compare_bit(trans_valid_o, 1'b1, "command valid one cycle after handshake");
        compare_ca(trans_ca_o, expected_ca(addr, 1'b1), "read command word");
        compare_cs(trans_cs_o, expected_cs(addr), "read chip select");
        compare_burst(trans_burst_o, expected_burst(len), "read burst length");
        @(negedge clk_i);
        trans_ready_i = 1'b1;
        @(negedge clk_i);
        trans_ready_i = 1'b0;
    endtask

    task automatic test_write_split(input bit stall);
        data_t       beats[$];
        strb_t       strbs[$];
        hyper_word_t want_word[$];
        hyper_strb_t want_strb[$];
        logic        want_last[$];
        data_t       beat;
        strb_t       strb;
        int          n, sent, steps, i;
        n = 1 + int'($urandom % 4);
        for (i = 0; i < n; i++) begin
            beat = $urandom;
            strb = strb_t'($urandom);
            beats.push_back(beat);
            strbs.push_back(strb);
            want_word.push_back(beat[15:0]);
            want_word.push_back(beat[31:16]);
            want_strb.push_back(strb[1:0]);
            want_strb.push_back(strb[3:2]);
            want_last.push_back(1'b0);
            want_last.push_back(i == n - 1);
        end
        sent  = 0;
        steps = 0;
        while (want_word.size() != 0) begin
            @(negedge clk_i);
            w_valid_i  = (sent < n);
            w_data_i   = (sent < n) ? beats[sent] : '0;
            w_strb_i   = (sent < n) ? strbs[sent] : '0;
            w_last_i   = (sent == n - 1);
            tx_ready_i = stall ? 1'($urandom % 2) : 1'b1;
            #1;
            if (tx_valid_o && tx_ready_i) begin
                compare_word(tx_data_o, want_word.pop_front(), "write word");
                compare_strb(tx_strb_o, want_strb.pop_front(), "write word strobes");
                compare_bit(tx_last_o, want_last.pop_front(), "write word last flag");
            end
            if (w_valid_i && w_ready_o) begin
                sent++;
            end
            steps++;
            if (steps > TIMEOUT) begin
                timeout_hit("the write words");
                return;
            end
        end
        @(negedge clk_i);
        w_valid_i = 1'b0;
        w_last_i  = 1'b0;
        #1;
        compare_bit(tx_valid_o, 1'b0, "no write word after the burst");
    endtask

    task automatic test_read_merge(input bit stall);
        hyper_word_t words[$];
        int          n, nw, err_idx, idx, got, steps, i;
        n       = 1 + int'($urandom % 4);
        nw      = 2 * n;
        err_idx = int'($urandom % nw);
        for (i = 0; i < nw; i++) begin
            words.push_back(hyper_word_t'($urandom));
        end
        idx   = 0;
        got   = 0;
        steps = 0;
        while (got < n) begin
            @(negedge clk_i);
            rx_valid_i = (idx < nw);
            rx_data_i  = (idx < nw) ? words[idx] : '0;
            rx_error_i = (idx == err_idx);
            rx_last_i  = (idx == nw - 1);
            r_ready_i  = stall ? 1'($urandom % 2) : 1'b1;
            #1;
            if (r_valid_o && r_ready_i) begin
                compare_beat(r_data_o, {words[2*got+1], words[2*got]}, "read beat");
                compare_bit(r_error_o, (err_idx / 2) == got, "read beat error");
                compare_bit(r_last_o, got == n - 1, "read beat last flag");
                got++;
            end
            if (rx_valid_i && rx_ready_o) begin
                idx++;
            end
            steps++;
            if (steps > TIMEOUT) begin
                timeout_hit("the read beats");
                return;
            end
        end
        @(negedge clk_i);
        rx_valid_i = 1'b0;
        rx_error_i = 1'b0;
        rx_last_i  = 1'b0;
        compare_bit(idx == nw, 1'b1, "all read words consumed");
    endtask

    // Mixed requests, one at a time, with the PHY taking commands
    task automatic test_command_stream(input bit stall);
        logic [CA_W-1:0] want_ca[$];
        cs_t             want_cs[$];
        hyper_burst_t    want_burst[$];
        logic            is_read;
        addr_t           addr;
        len_t            len;
        int              issued, seen, steps;
        random_request(is_read, addr, len);
        issued = 0;
        seen   = 0;
        steps  = 0;
        while (seen < NUM_CMDS) begin
            @(negedge clk_i);
            ar_valid_i    = (issued < NUM_CMDS) && is_read;
            aw_valid_i    = (issued < NUM_CMDS) && !is_read;
            ar_addr_i     = addr;
            aw_addr_i     = addr;
            ar_len_i      = len;
            aw_len_i      = len;
            trans_ready_i = stall ? 1'($urandom % 2) : 1'b1;
            #1;
            if (trans_valid_o && trans_ready_i) begin
                compare_ca(trans_ca_o, want_ca.pop_front(), "command word");
                compare_cs(trans_cs_o, want_cs.pop_front(), "chip select");
                compare_burst(trans_burst_o, want_burst.pop_front(), "burst length");
                seen++;
            end
            if ((ar_valid_i && ar_ready_o) || (aw_valid_i && aw_ready_o)) begin
                want_ca.push_back(expected_ca(addr, is_read));
                want_cs.push_back(expected_cs(addr));
                want_burst.push_back(expected_burst(len));
                issued++;
                random_request(is_read, addr, len);
            end
            steps++;
            if (steps > TIMEOUT) begin
                timeout_hit("the PHY commands");
                return;
            end
        end
        @(negedge clk_i);
        trans_ready_i = 1'b0;
        #1;
        compare_bit(trans_valid_o, 1'b0, "no command beyond the last one");
    endtask

    task automatic test_arbitration();
        logic [CA_W-1:0] want_ca[$];
        logic            unused_kind, want_read;
        addr_t           rd_addr, wr_addr;
        len_t            rd_len, wr_len;
        int              grants, seen, steps;
        // Fresh reset so that read holds the first priority
        reset_dut();
        random_request(unused_kind, rd_addr, rd_len);
        random_request(unused_kind, wr_addr, wr_len);
        want_read = 1'b1;
        grants    = 0;
        seen      = 0;
        steps     = 0;
        while (seen < NUM_CMDS) begin
            @(negedge clk_i);
            ar_valid_i    = (grants < NUM_CMDS);
            aw_valid_i    = (grants < NUM_CMDS);
            ar_addr_i     = rd_addr;
            ar_len_i      = rd_len;
            aw_addr_i     = wr_addr;
            aw_len_i      = wr_len;
            trans_ready_i = 1'b1;
            #1;
            if (trans_valid_o && trans_ready_i) begin
                compare_ca(trans_ca_o, want_ca.pop_front(), "arbitrated command word");
                seen++;
            end
            if (ar_valid_i && (ar_ready_o || aw_ready_o)) begin
                compare_bit(ar_ready_o, want_read, "read channel granted in turn");
                want_ca.push_back(want_read ? expected_ca(rd_addr, 1'b1)
                                            : expected_ca(wr_addr, 1'b0));
                if (ar_ready_o) begin
                    random_request(unused_kind, rd_addr, rd_len);
                end else begin
                    random_request(unused_kind, wr_addr, wr_len);
                end
                want_read = !want_read;
                grants++;
            end
            steps++;
            if (steps > TIMEOUT) begin
                timeout_hit("the arbitrated commands");
                return;
            end
        end
        @(negedge clk_i);
        trans_ready_i = 1'b0;
        #1;
        compare_bit(trans_valid_o, 1'b0, "no extra arbitrated command");
    endtask

    task automatic test_write_response();
        int i;
        for (i = 0; i < 8; i++) begin
            @(negedge clk_i);
            b_valid_i = 1'($urandom % 2);
            b_error_i = 1'($urandom % 2);
            b_ready_i = 1'($urandom % 2);
            #1;
            compare_bit(b_valid_o, b_valid_i, "response valid");
            compare_bit(b_error_o, b_error_i, "response error");
            compare_bit(b_ready_o, b_ready_i, "response ready");
        end
        @(negedge clk_i);
        b_valid_i = 1'b0;
        b_error_i = 1'b0;
        b_ready_i = 1'b0;
    endtask

    initial begin
        rst_ni        = 1'b0;
        ar_valid_i    = 1'b0;
        ar_addr_i     = '0;
        ar_len_i      = '0;
        aw_valid_i    = 1'b0;
        aw_addr_i     = '0;
        aw_len_i      = '0;
        w_valid_i     = 1'b0;
        w_data_i      = '0;
        w_strb_i      = '0;
        w_last_i      = 1'b0;
        r_ready_i     = 1'b0;
        b_ready_i     = 1'b0;
        trans_ready_i = 1'b0;
        tx_ready_i    = 1'b0;
        rx_valid_i    = 1'b0;
        rx_data_i     = '0;
        rx_error_i    = 1'b0;
        rx_last_i     = 1'b0;
        b_valid_i     = 1'b0;
        b_error_i     = 1'b0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        mark          = 0;
        hung          = 1'b0;
        void'($urandom(32'hece4));
        reset_dut();

        test_single_read(1'b0);
        if (!hung) test_single_read(1'b1);
        finish_test("single read command");
        if (!hung) begin
            test_write_split(1'b0);
            finish_test("write burst split");
        end
        if (!hung) begin
            test_read_merge(1'b0);
            finish_test("read burst merge");
        end
        if (!hung) begin
            test_arbitration();
            finish_test("read/write arbitration");
        end
        if (!hung) begin
            test_command_stream(1'b1);
            if (!hung) test_write_split(1'b1);
            if (!hung) test_read_merge(1'b1);
            if (!hung) test_write_split(1'b1);
            if (!hung) test_read_merge(1'b1);
            finish_test("back-pressure");
        end
        if (!hung) begin
            test_write_response();
            finish_test("write response");
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !hung) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/bus_pkg.sv
hdl/hyper_pkg.sv
hdl/hyper_ax_arbiter.sv
hdl/hyper_cmd_builder.sv
hdl/hyper_w_split.sv
hdl/hyper_r_merge.sv
hdl/hyper_frontend.sv
tests/hyper_frontend_assert.sv
tests/tb_hyper_frontend.sv
